//--- src/ram_flops_settings.svh
/*
  Geometry of the flip-flop RAM. RAM_DEPTH and RAM_DEPTH_TILES must be powers of two,
  with at least two tiles. RAM_WORD_WIDTH must divide RAM_WIDTH.
*/
`ifndef RAM_FLOPS_SETTINGS_SVH
`define RAM_FLOPS_SETTINGS_SVH

// Total number of entries
`define RAM_DEPTH 64

// Depth tiles, each holding RAM_DEPTH / RAM_DEPTH_TILES entries
`define RAM_DEPTH_TILES 4

// Bits per entry
`define RAM_WIDTH 32

// Smallest unit that a partial write can update
`define RAM_WORD_WIDTH 8

// Independent read ports
`define RAM_NUM_RD_PORTS 2

`endif

//--- src/ram_flops_pkg.sv
/*
  Derived widths and request/response structs of the flip-flop RAM.
  Address split assumes power-of-two depth and tile count.
*/
`include "ram_flops_settings.svh"

package ram_flops_pkg;

  // ----------------------------------------------------------
  // Derived sizes
  // ----------------------------------------------------------
  localparam int ADDR_W = $clog2(`RAM_DEPTH);
  localparam int TILE_DEPTH = `RAM_DEPTH / `RAM_DEPTH_TILES;
  localparam int TILE_ADDR_W = $clog2(TILE_DEPTH);
  localparam int TILE_SEL_W = $clog2(`RAM_DEPTH_TILES);
  localparam int NUM_WORDS = `RAM_WIDTH / `RAM_WORD_WIDTH;

  // One entry and its per-word write mask
  typedef logic [`RAM_WIDTH-1:0] data_t;
  typedef logic [NUM_WORDS-1:0] word_en_t;

  // External write port
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    data_t             data;
    word_en_t          word_en;
  } wr_req_t;

  // One external read port
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  // Read response, tile to mux and mux to outside
  typedef struct packed {
    logic  valid;
    data_t data;
  } rd_resp_t;

  // Write request after decode, address local to the tile
  typedef struct packed {
    logic                   valid;
    logic [TILE_ADDR_W-1:0] addr;
    data_t                  data;
    word_en_t               word_en;
  } tile_wr_t;

  // Read request after decode
  typedef struct packed {
    logic                   valid;
    logic [TILE_ADDR_W-1:0] addr;
  } tile_rd_t;

endpackage

//--- src/ram_addr_decode.sv
/*
  Registered address decode. One cycle from request to tile signals.
  Upper address bits pick the tile, only that tile sees valid.
  No back-pressure, every valid request is taken.
*/
`timescale 1ns/1ps
`include "ram_flops_settings.svh"

module ram_addr_decode (
  input  logic                                                                 clk,
  input  logic                                                                 rst,
  input  ram_flops_pkg::wr_req_t                                               wr,
  input  ram_flops_pkg::rd_req_t [`RAM_NUM_RD_PORTS-1:0]                       rd,
  output ram_flops_pkg::tile_wr_t [`RAM_DEPTH_TILES-1:0]                       tile_wr,
  output ram_flops_pkg::tile_rd_t [`RAM_DEPTH_TILES-1:0][`RAM_NUM_RD_PORTS-1:0] tile_rd
);
  import ram_flops_pkg::*;

  // Address split of the incoming requests
  logic [TILE_SEL_W-1:0] wr_sel;
  logic [TILE_ADDR_W-1:0] wr_local;
  logic [`RAM_NUM_RD_PORTS-1:0][TILE_SEL_W-1:0] rd_sel;
  logic [`RAM_NUM_RD_PORTS-1:0][TILE_ADDR_W-1:0] rd_local;

  // One-hot tile hits before the register
  logic [`RAM_DEPTH_TILES-1:0] wr_hit;
  logic [`RAM_NUM_RD_PORTS-1:0][`RAM_DEPTH_TILES-1:0] rd_hit;

  // Registered stage
  logic [`RAM_DEPTH_TILES-1:0] wr_hit_q;
  logic [TILE_ADDR_W-1:0] wr_addr_q;
  data_t wr_data_q;
  word_en_t wr_word_en_q;
  logic [`RAM_NUM_RD_PORTS-1:0][`RAM_DEPTH_TILES-1:0] rd_hit_q;
  logic [`RAM_NUM_RD_PORTS-1:0][TILE_ADDR_W-1:0] rd_addr_q;

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------
  always_comb begin
    // Top bits select the tile, low bits index inside it
    wr_sel = wr.addr[ADDR_W-1 -: TILE_SEL_W];
    wr_local = wr.addr[TILE_ADDR_W-1:0];
    for (int t = 0; t < `RAM_DEPTH_TILES; t++) begin
      wr_hit[t] = wr.valid && (wr_sel == TILE_SEL_W'(t));
    end
    for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
      rd_sel[p] = rd[p].addr[ADDR_W-1 -: TILE_SEL_W];
      rd_local[p] = rd[p].addr[TILE_ADDR_W-1:0];
      for (int t = 0; t < `RAM_DEPTH_TILES; t++) begin
        rd_hit[p][t] = rd[p].valid && (rd_sel[p] == TILE_SEL_W'(t));
      end
    end
  end

  // ----------------------------------------------------------
  // Request register
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_hit_q <= '0;
      rd_hit_q <= '0;
    end else begin
      wr_hit_q <= wr_hit;
      rd_hit_q <= rd_hit;
    end
  end

  // Payload only moves with a request
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      wr_addr_q <= wr_local;
      wr_data_q <= wr.data;
      wr_word_en_q <= wr.word_en;
    end
    for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
      if (rd[p].valid) begin
        rd_addr_q[p] <= rd_local[p];
      end
    end
  end

  // Fan out to the tiles, shared payload and per-tile valid
  always_comb begin
    for (int t = 0; t < `RAM_DEPTH_TILES; t++) begin
      tile_wr[t].valid = wr_hit_q[t];
      tile_wr[t].addr = wr_addr_q;
      tile_wr[t].data = wr_data_q;
      tile_wr[t].word_en = wr_word_en_q;
      for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
        tile_rd[t][p].valid = rd_hit_q[p][t];
        tile_rd[t][p].addr = rd_addr_q[p];
      end
    end
  end

  // Requests must stay inside the RAM
  wr_addr_in_range_a: assert property (@(posedge clk) disable iff (rst)
    wr.valid |-> (int'(wr.addr) < `RAM_DEPTH));

  for (genvar p = 0; p < `RAM_NUM_RD_PORTS; p++) begin : gen_rd_range
    rd_addr_in_range_a: assert property (@(posedge clk) disable iff (rst)
      rd[p].valid |-> (int'(rd[p].addr) < `RAM_DEPTH));
  end

endmodule

//--- src/ram_flop_tile.sv
/*
  One depth tile of flip-flop storage, cleared on reset.
  Write lands on the edge after tile_wr valid. Reads are combinational,
  so a read in the same cycle as a write sees the old entry.
*/
`timescale 1ns/1ps
`include "ram_flops_settings.svh"

module ram_flop_tile (
  input  logic                                            clk,
  input  logic                                            rst,
  input  ram_flops_pkg::tile_wr_t                         tile_wr,
  input  ram_flops_pkg::tile_rd_t [`RAM_NUM_RD_PORTS-1:0] tile_rd,
  output ram_flops_pkg::rd_resp_t [`RAM_NUM_RD_PORTS-1:0] rd_resp
);
  import ram_flops_pkg::*;

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------
  // Entries kept as words so the write mask maps directly
  logic [NUM_WORDS-1:0][`RAM_WORD_WIDTH-1:0] mem [TILE_DEPTH];

  // Write data cut into the same words
  logic [NUM_WORDS-1:0][`RAM_WORD_WIDTH-1:0] wr_words;

  assign wr_words = tile_wr.data;

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      // Whole tile reads as zero after reset
      for (int i = 0; i < TILE_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (tile_wr.valid) begin
      // Masked words keep their old value
      for (int w = 0; w < NUM_WORDS; w++) begin
        if (tile_wr.word_en[w]) begin
          mem[tile_wr.addr][w] <= wr_words[w];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Read ports
  // ----------------------------------------------------------
  // Valid follows the request in the same cycle
  // Data is not gated, the mux qualifies it with valid
  always_comb begin
    for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
      rd_resp[p].valid = tile_rd[p].valid;
      rd_resp[p].data = mem[tile_rd[p].addr];
    end
  end

  // A write that reaches a tile must change at least one word
  wr_word_en_nonzero_a: assert property (@(posedge clk) disable iff (rst)
    tile_wr.valid |-> (tile_wr.word_en != '0));

endmodule

//--- src/ram_rd_mux.sv
/*
  Read data stage. Per port, picks the answering tile and registers it.
  At most one tile may answer a port in a cycle.
*/
`timescale 1ns/1ps
`include "ram_flops_settings.svh"

module ram_rd_mux (
  input  logic clk,
  input  logic rst,
  input  ram_flops_pkg::rd_resp_t [`RAM_DEPTH_TILES-1:0][`RAM_NUM_RD_PORTS-1:0] tile_resp,
  output ram_flops_pkg::rd_resp_t [`RAM_NUM_RD_PORTS-1:0]                       rd_resp
);
  import ram_flops_pkg::*;

  // Which tiles answer each port
  logic [`RAM_NUM_RD_PORTS-1:0][`RAM_DEPTH_TILES-1:0] hit;
  logic [`RAM_NUM_RD_PORTS-1:0] any_hit;

  // AND-OR of the qualified tile data
  data_t [`RAM_NUM_RD_PORTS-1:0] or_data;

  // Output register
  logic [`RAM_NUM_RD_PORTS-1:0] valid_q;
  data_t [`RAM_NUM_RD_PORTS-1:0] data_q;

  // ----------------------------------------------------------
  // Tile select
  // ----------------------------------------------------------
  always_comb begin
    for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
      or_data[p] = '0;
      for (int t = 0; t < `RAM_DEPTH_TILES; t++) begin
        hit[p][t] = tile_resp[t][p].valid;
        // Idle tiles contribute zeros
        or_data[p] = or_data[p] | (tile_resp[t][p].data & {`RAM_WIDTH{hit[p][t]}});
      end
      any_hit[p] = |hit[p];
    end
  end

  // ----------------------------------------------------------
  // Response register
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= any_hit;
    end
  end

  // Data held between responses
  always_ff @(posedge clk) begin
    for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
      if (any_hit[p]) begin
        data_q[p] <= or_data[p];
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
      rd_resp[p].valid = valid_q[p];
      rd_resp[p].data = data_q[p];
    end
  end

  // Decode steers each read to a single tile
  for (genvar p = 0; p < `RAM_NUM_RD_PORTS; p++) begin : gen_one_hot
    one_tile_answers_a: assert property (@(posedge clk) disable iff (rst)
      $onehot0(hit[p]));
  end

endmodule

//--- src/ram_flops.sv
/*
  Flip-flop RAM, one write port with word mask and RAM_NUM_RD_PORTS read ports.
  Read latency is 2 cycles. A write is visible to reads issued one cycle later.
  Single clock, no back-pressure, addresses must be below RAM_DEPTH.
*/
`timescale 1ns/1ps
`include "ram_flops_settings.svh"

module ram_flops (
  input  logic                                            clk,
  input  logic                                            rst,
  input  ram_flops_pkg::wr_req_t                          wr,
  input  ram_flops_pkg::rd_req_t [`RAM_NUM_RD_PORTS-1:0]  rd,
  output ram_flops_pkg::rd_resp_t [`RAM_NUM_RD_PORTS-1:0] rd_resp
);
  import ram_flops_pkg::*;

  // Decoded requests, one set per tile
  tile_wr_t [`RAM_DEPTH_TILES-1:0] tile_wr;
  tile_rd_t [`RAM_DEPTH_TILES-1:0][`RAM_NUM_RD_PORTS-1:0] tile_rd;

  // Raw tile responses into the read mux
  rd_resp_t [`RAM_DEPTH_TILES-1:0][`RAM_NUM_RD_PORTS-1:0] tile_resp;

  // ----------------------------------------------------------
  // Address stage
  // ----------------------------------------------------------
  ram_addr_decode decode (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .rd      (rd),
    .tile_wr (tile_wr),
    .tile_rd (tile_rd)
  );

  // ----------------------------------------------------------
  // Depth tiles
  // ----------------------------------------------------------
  for (genvar t = 0; t < `RAM_DEPTH_TILES; t++) begin : gen_tile
    // Tile t holds addresses t*TILE_DEPTH up to (t+1)*TILE_DEPTH-1
    ram_flop_tile tile (
      .clk     (clk),
      .rst     (rst),
      .tile_wr (tile_wr[t]),
      .tile_rd (tile_rd[t]),
      .rd_resp (tile_resp[t])
    );
  end

  // ----------------------------------------------------------
  // Read data stage
  // ----------------------------------------------------------
  ram_rd_mux rd_mux (
    .clk       (clk),
    .rst       (rst),
    .tile_resp (tile_resp),
    .rd_resp   (rd_resp)
  );

endmodule

//--- tb/ram_flops_tb.sv
/*
  Directed testbench for the flip-flop RAM. Inputs change on the falling edge.
  Responses are checked two falling edges after their request, against a model
  in which a write becomes visible to reads issued one cycle later.
*/
`timescale 1ns/1ps
`include "ram_flops_settings.svh"

module ram_flops_tb;
  import ram_flops_pkg::*;

  // Tests take roughly 500 cycles in total
  localparam int TIMEOUT_CYCLES = 3000;

  logic clk = 1'b0;
  logic rst;
  wr_req_t wr;
  rd_req_t [`RAM_NUM_RD_PORTS-1:0] rd;
  rd_resp_t [`RAM_NUM_RD_PORTS-1:0] rd_resp;

  // Reference contents, expected responses in flight, newest at index 0
  data_t model [`RAM_DEPTH];
  rd_resp_t [`RAM_NUM_RD_PORTS-1:0] exp_pipe [2];

  integer seed = 81713;
  int cycle_count = 0;

  ram_flops dut0 (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .rd      (rd),
    .rd_resp (rd_resp)
  );

  // 4 ns period
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $fatal(1, "Simulation timed out");
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  function automatic wr_req_t write_req(input logic [ADDR_W-1:0] addr, input data_t data,
                                        input word_en_t en);
    wr_req_t req;
    req.valid = 1'b1;
    req.addr = addr;
    req.data = data;
    req.word_en = en;
    return req;
  endfunction

  function automatic rd_req_t read_req(input logic [ADDR_W-1:0] addr);
    rd_req_t req;
    req.valid = 1'b1;
    req.addr = addr;
    return req;
  endfunction

  // One clock cycle, entered and left on a falling edge
  task automatic run_cycle(input wr_req_t wr_in, input rd_req_t [`RAM_NUM_RD_PORTS-1:0] rd_in);
    rd_resp_t [`RAM_NUM_RD_PORTS-1:0] expected;
    // Responses to the requests of two cycles back
    for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
      check_value($sformatf("rd_resp[%0d].valid", p), data_t'(rd_resp[p].valid),
                  data_t'(exp_pipe[1][p].valid));
      if (exp_pipe[1][p].valid) begin
        check_value($sformatf("rd_resp[%0d].data", p), rd_resp[p].data, exp_pipe[1][p].data);
      end
    end
    wr = wr_in;
    rd = rd_in;
    // Reads see the model before this cycle's write lands
    for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
      expected[p].valid = rd_in[p].valid;
      expected[p].data = rd_in[p].valid ? model[rd_in[p].addr] : '0;
    end
    exp_pipe[1] = exp_pipe[0];
    exp_pipe[0] = expected;
    // Masked words keep their old value
    if (wr_in.valid) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        if (wr_in.word_en[w]) begin
          model[wr_in.addr][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] =
            wr_in.data[w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
        end
      end
    end
    @(negedge clk);
  endtask

  // Idle until every response in flight has been checked
  task automatic drain();
    repeat (2) run_cycle('0, '0);
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_reset_state();
    rd_req_t [`RAM_NUM_RD_PORTS-1:0] rd_v;
    // Even ports walk up, odd ports walk down
    for (int a = 0; a < `RAM_DEPTH; a++) begin
      for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
        rd_v[p] = read_req(ADDR_W'((p % 2 == 0) ? a : `RAM_DEPTH - 1 - a));
      end
      run_cycle('0, rd_v);
    end
    drain();
  endtask

  task automatic test_full_writes();
    rd_req_t [`RAM_NUM_RD_PORTS-1:0] rd_v;
    for (int a = 0; a < `RAM_DEPTH; a++) begin
      run_cycle(write_req(ADDR_W'(a), data_t'($random(seed)), '1), '0);
    end
    // Two passes, order swapped between ports on the second
    for (int pass = 0; pass < 2; pass++) begin
      for (int a = 0; a < `RAM_DEPTH; a++) begin
        for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
          rd_v[p] = read_req(ADDR_W'(((p + pass) % 2 == 0) ? a : `RAM_DEPTH - 1 - a));
        end
        run_cycle('0, rd_v);
      end
    end
    drain();
  endtask

  task automatic test_partial_writes();
    logic [ADDR_W-1:0] addrs [4] = '{6'd3, 6'd20, 6'd45, 6'd63};
    word_en_t masks [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                            4'b0101, 4'b1010, 4'b0110, 4'b1001};
    rd_req_t [`RAM_NUM_RD_PORTS-1:0] rd_v;
    for (int i = 0; i < 4; i++) begin
      for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
        rd_v[p] = read_req(addrs[i]);
      end
      // Full base value, then one masked write per read-back
      run_cycle(write_req(addrs[i], data_t'($random(seed)), '1), '0);
      for (int m = 0; m < 8; m++) begin
        run_cycle(write_req(addrs[i], data_t'($random(seed)), masks[m]), '0);
        run_cycle('0, rd_v);
      end
    end
    drain();
  endtask

  task automatic test_write_read_order();
    rd_req_t [`RAM_NUM_RD_PORTS-1:0] rd_v;
    rd_v = '0;
    // Same cycle returns old data
    rd_v[0] = read_req(6'd37);
    run_cycle(write_req(6'd37, 32'hA5C3_0F96, '1), rd_v);
    // One cycle later returns new data on every port
    for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
      rd_v[p] = read_req(6'd37);
    end
    run_cycle('0, rd_v);
    // Tile boundary, write at 15 while reading 16
    rd_v[0] = read_req(6'd16);
    rd_v[1] = read_req(6'd15);
    run_cycle(write_req(6'd15, 32'h1234_5678, 4'b0011), rd_v);
    run_cycle('0, rd_v);
    drain();
  endtask

  task automatic test_random_traffic();
    rd_req_t [`RAM_NUM_RD_PORTS-1:0] rd_v;
    wr_req_t w;
    logic [ADDR_W-1:0] last_wr_addr;
    last_wr_addr = '0;
    for (int c = 0; c < 200; c++) begin
      // Some reads chase the latest write
      for (int p = 0; p < `RAM_NUM_RD_PORTS; p++) begin
        if ({$random(seed)} % 4 == 0) begin
          rd_v[p] = read_req(last_wr_addr);
        end else begin
          rd_v[p] = read_req(ADDR_W'({$random(seed)}));
        end
      end
      if ({$random(seed)} % 2 == 0) begin
        w = write_req(ADDR_W'({$random(seed)}), data_t'($random(seed)),
                      word_en_t'({$random(seed)} % ((1 << NUM_WORDS) - 1) + 1));
        last_wr_addr = w.addr;
      end else begin
        w = '0;
      end
      run_cycle(w, rd_v);
    end
    drain();
  endtask

  // ----------------------------------------------------------
  // Sequence
  // ----------------------------------------------------------
  initial begin
    rst = 1'b1;
    wr = '0;
    rd = '0;
    // Reset clears every entry
    for (int a = 0; a < `RAM_DEPTH; a++) begin
      model[a] = '0;
    end
    exp_pipe[0] = '0;
    exp_pipe[1] = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_full_writes();
    test_partial_writes();
    test_write_read_order();
    test_random_traffic();

    $display("Regression passed");
    $finish;
  end

endmodule

//--- ram_flops.f
+incdir+src
src/ram_flops_pkg.sv
src/ram_addr_decode.sv
src/ram_flop_tile.sv
src/ram_rd_mux.sv
src/ram_flops.sv
tb/ram_flops_tb.sv

//--- Makefile
# Verilator flow for the flip-flop RAM

TOP   = ram_flops_tb
FLIST = ram_flops.f

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f $(FLIST) --top-module $(TOP) -o sim

# Pass or fail comes from the log, not the exit status of the simulator
run: build
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps -Isrc \
	  src/ram_flops_pkg.sv src/ram_addr_decode.sv src/ram_flop_tile.sv \
	  src/ram_rd_mux.sv src/ram_flops.sv --top-module ram_flops

clean:
	rm -rf obj_dir sim.log
